/* clk_monitor.f */
+incdir+rtl
rtl/clk_monitor_pkg.sv
rtl/monitor_apb_regs.sv
rtl/ext_clk_meter.sv
rtl/heartbeat_timer.sv
rtl/panel_driver.sv
rtl/clk_monitor_top.sv
sim/tb_clk_monitor.sv

/* rtl/clk_monitor_defs.svh */
`ifndef CLK_MONITOR_DEFS_SVH
`define CLK_MONITOR_DEFS_SVH

// APB bus sizes
`define APB_ADDR_W   8
`define APB_DATA_W   32

// register map, byte addresses
`define REG_CTRL     8'h00
`define REG_WINDOW   8'h04
`define REG_LIMIT    8'h08
`define REG_FREQ     8'h0C      // read only
`define REG_STATUS   8'h10      // read only

// counter widths
`define WINDOW_W     24
`define FREQ_W       32
`define HEARTBEAT_W  26

// register reset values
`define WINDOW_RESET 1000       // clk_usb cycles per measurement
`define LIMIT_RESET  4          // allowed count drift between windows

`endif

/* rtl/clk_monitor_pkg.sv */
`include "clk_monitor_defs.svh"

package clk_monitor_pkg;

   typedef enum logic [1:0] {
      LED_STATUS    = 2'd0,
      LED_HEARTBEAT = 2'd1,
      LED_METER     = 2'd2,
      LED_GAIN      = 2'd3
   } led_mode_t;

   // CTRL register layout, LSB last
   typedef struct packed {
      logic [19:0] reserved;
      logic        clear_change;     // write one to clear, reads zero
      logic        monitor_disable;
      led_mode_t   led_mode;
      logic [7:0]  gain;
   } ctrl_fields_t;

   typedef union packed {
      logic [`APB_DATA_W-1:0] raw;
      ctrl_fields_t           f;
   } ctrl_word_u;

   typedef struct packed {
      logic [`WINDOW_W-1:0] window;
      logic [`FREQ_W-1:0]   limit;
      logic                 monitor_disable;
      logic                 clear_change;
   } meter_cfg_t;

   typedef struct packed {
      logic [`FREQ_W-1:0] freq;
      logic               valid;
      logic               change;
      logic               measure_pulse;
   } meter_result_t;

   typedef struct packed {
      logic [7:0] gain;
      led_mode_t  led_mode;
   } panel_cfg_t;

endpackage

/* rtl/clk_monitor_top.sv */
`timescale 1ns/1ps
`include "clk_monitor_defs.svh"

module clk_monitor_top import clk_monitor_pkg::*; (
   input  logic                   clk_usb,
   input  logic                   reset,
   input  logic [`APB_ADDR_W-1:0] paddr_i,
   input  logic                   psel_i,
   input  logic                   penable_i,
   input  logic                   pwrite_i,
   input  logic [`APB_DATA_W-1:0] pwdata_i,
   input  logic                   ext_clk_i,      // target clock, below clk_usb/2
   output logic [`APB_DATA_W-1:0] prdata_o,
   output logic                   pready_o,
   output logic                   pslverr_o,
   output logic                   led_a_o,
   output logic                   led_b_o,
   output logic                   amp_gain_o
);

   meter_cfg_t    meter_cfg;
   panel_cfg_t    panel_cfg;
   meter_result_t meter_result;
   logic [1:0]    beat;
   logic          flash;

   monitor_apb_regs regs_i (
      .clk_usb     (clk_usb),
      .reset       (reset),
      .paddr_i     (paddr_i),
      .psel_i      (psel_i),
      .penable_i   (penable_i),
      .pwrite_i    (pwrite_i),
      .pwdata_i    (pwdata_i),
      .result_i    (meter_result),
      .prdata_o    (prdata_o),
      .pready_o    (pready_o),
      .pslverr_o   (pslverr_o),
      .meter_cfg_o (meter_cfg),
      .panel_cfg_o (panel_cfg)
   );

   ext_clk_meter meter_i (
      .clk_usb   (clk_usb),
      .reset     (reset),
      .ext_clk_i (ext_clk_i),
      .cfg_i     (meter_cfg),
      .result_o  (meter_result)
   );

   heartbeat_timer heartbeat_i (
      .clk_usb (clk_usb),
      .reset   (reset),
      .beat_o  (beat),
      .flash_o (flash)
   );

   panel_driver panel_i (
      .clk_usb    (clk_usb),
      .reset      (reset),
      .cfg_i      (panel_cfg),
      .result_i   (meter_result),
      .beat_i     (beat),
      .flash_i    (flash),
      .ext_clk_i  (ext_clk_i),
      .led_a_o    (led_a_o),
      .led_b_o    (led_b_o),
      .amp_gain_o (amp_gain_o)
   );

endmodule

/* rtl/ext_clk_meter.sv */
`timescale 1ns/1ps
`include "clk_monitor_defs.svh"

module ext_clk_meter import clk_monitor_pkg::*; (
   input  logic          clk_usb,
   input  logic          reset,
   input  logic          ext_clk_i,
   input  meter_cfg_t    cfg_i,
   output meter_result_t result_o
);

   logic                 ext_meta;
   logic                 ext_sync;
   logic                 ext_prev;
   logic                 rise;
   logic [`WINDOW_W-1:0] win_left;     // cycles left in current window
   logic [`WINDOW_W-1:0] win_len_m1;
   logic                 win_end;
   logic [`FREQ_W-1:0]   edge_cnt;
   logic [`FREQ_W-1:0]   new_cnt;
   logic [`FREQ_W-1:0]   diff;
   logic [`FREQ_W-1:0]   freq_q;
   logic                 valid_q;
   logic                 change_q;
   logic                 pulse_q;

   // target clock must stay below half of clk_usb for this to see every edge
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ext_meta <= 1'b0;
         ext_sync <= 1'b0;
         ext_prev <= 1'b0;
      end else begin
         ext_meta <= ext_clk_i;
         ext_sync <= ext_meta;
         ext_prev <= ext_sync;
      end
   end

   assign rise    = ext_sync & ~ext_prev;
   assign win_end = (win_left == '0);
   assign new_cnt = edge_cnt + `FREQ_W'(rise);   // includes an edge on the last cycle
   assign diff    = (new_cnt > freq_q) ? (new_cnt - freq_q) : (freq_q - new_cnt);

   // windows shorter than two cycles are stretched to two
   assign win_len_m1 = (cfg_i.window < `WINDOW_W'(2)) ? `WINDOW_W'(1)
                                                    : cfg_i.window - `WINDOW_W'(1);

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         win_left <= `WINDOW_W'(`WINDOW_RESET - 1);
         edge_cnt <= '0;
         freq_q   <= '0;
         valid_q  <= 1'b0;
         pulse_q  <= 1'b0;
      end else begin
         pulse_q <= win_end;
         if (win_end) begin
            win_left <= win_len_m1;     // length latched at window start
            edge_cnt <= '0;
            freq_q   <= new_cnt;
            valid_q  <= 1'b1;
         end else begin
            win_left <= win_left - `WINDOW_W'(1);
            edge_cnt <= new_cnt;
         end
      end
   end

   // sticky alarm on a jump between consecutive measurements
   always_ff @(posedge clk_usb) begin
      if (reset)
         change_q <= 1'b0;
      else if (cfg_i.monitor_disable || cfg_i.clear_change)
         change_q <= 1'b0;
      else if (win_end && valid_q && (new_cnt != '0) && (diff > cfg_i.limit))
         change_q <= 1'b1;
   end

   always_comb begin
      result_o.freq          = freq_q;
      result_o.valid         = valid_q;
      result_o.change        = change_q;
      result_o.measure_pulse = pulse_q;
   end

   a_pulse_single: assert property (@(posedge clk_usb) disable iff (reset)
      pulse_q |=> !pulse_q);

endmodule

/* rtl/heartbeat_timer.sv */
`timescale 1ns/1ps
`include "clk_monitor_defs.svh"

module heartbeat_timer (
   input  logic       clk_usb,
   input  logic       reset,
   output logic [1:0] beat_o,
   output logic       flash_o
);

   logic [`HEARTBEAT_W-1:0] count_q;
   logic                    flash_q;

   always_ff @(posedge clk_usb) begin
      if (reset)
         count_q <= '0;
      else
         count_q <= count_q + `HEARTBEAT_W'(1);   // free running, wraps
   end

   // blink only during the upper half of the period, then hold
   always_ff @(posedge clk_usb) begin
      if (reset)
         flash_q <= 1'b0;
      else if (count_q[`HEARTBEAT_W-1])
         flash_q <= ~count_q[`HEARTBEAT_W-2];
   end

   assign beat_o  = count_q[`HEARTBEAT_W-1:`HEARTBEAT_W-2];
   assign flash_o = flash_q;

endmodule

/* rtl/monitor_apb_regs.sv */
`timescale 1ns/1ps
`include "clk_monitor_defs.svh"

module monitor_apb_regs import clk_monitor_pkg::*; (
   input  logic                   clk_usb,
   input  logic                   reset,
   input  logic [`APB_ADDR_W-1:0] paddr_i,
   input  logic                   psel_i,
   input  logic                   penable_i,
   input  logic                   pwrite_i,
   input  logic [`APB_DATA_W-1:0] pwdata_i,
   input  meter_result_t          result_i,
   output logic [`APB_DATA_W-1:0] prdata_o,
   output logic                   pready_o,
   output logic                   pslverr_o,
   output meter_cfg_t             meter_cfg_o,
   output panel_cfg_t             panel_cfg_o
);

   ctrl_word_u wr_word;                  // pwdata seen as CTRL fields
   ctrl_word_u ctrl_next;
   ctrl_word_u ctrl_q;
   logic [`WINDOW_W-1:0]   window_q;
   logic [`FREQ_W-1:0]     limit_q;
   logic                   clear_q;      // one-cycle clear_change pulse
   logic                   access;
   logic                   wr_en;
   logic                   addr_hit;
   logic [`APB_DATA_W-1:0] rdata;

   assign access = psel_i & penable_i;   // access phase, no wait states
   assign wr_en  = access & pwrite_i;

   always_comb begin
      wr_word.raw                  = pwdata_i;
      ctrl_next.raw                = '0;  // reserved bits and clear_change read zero
      ctrl_next.f.gain             = wr_word.f.gain;
      ctrl_next.f.led_mode         = wr_word.f.led_mode;
      ctrl_next.f.monitor_disable  = wr_word.f.monitor_disable;
   end

   // read mux and decode
   always_comb begin
      addr_hit = 1'b1;
      rdata    = '0;
      case (paddr_i)
         `REG_CTRL:   rdata = ctrl_q.raw;
         `REG_WINDOW: rdata = `APB_DATA_W'(window_q);
         `REG_LIMIT:  rdata = `APB_DATA_W'(limit_q);
         `REG_FREQ:   rdata = `APB_DATA_W'(result_i.freq);
         `REG_STATUS: rdata = `APB_DATA_W'({result_i.valid, result_i.change});
         default:     addr_hit = 1'b0;
      endcase
   end

   assign prdata_o  = rdata;
   assign pready_o  = 1'b1;
   assign pslverr_o = access & ~addr_hit;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ctrl_q.raw <= '0;
         window_q   <= `WINDOW_W'(`WINDOW_RESET);
         limit_q    <= `FREQ_W'(`LIMIT_RESET);
         clear_q    <= 1'b0;
      end else begin
         clear_q <= 1'b0;
         if (wr_en) begin
            case (paddr_i)
               `REG_CTRL: begin
                  ctrl_q  <= ctrl_next;
                  clear_q <= wr_word.f.clear_change;
               end
               `REG_WINDOW: window_q <= pwdata_i[`WINDOW_W-1:0];
               `REG_LIMIT:  limit_q  <= pwdata_i[`FREQ_W-1:0];
               default: ;   // FREQ, STATUS and holes ignore writes
            endcase
         end
      end
   end

   always_comb begin
      meter_cfg_o.window          = window_q;
      meter_cfg_o.limit           = limit_q;
      meter_cfg_o.monitor_disable = ctrl_q.f.monitor_disable;
      meter_cfg_o.clear_change    = clear_q;
      panel_cfg_o.gain            = ctrl_q.f.gain;
      panel_cfg_o.led_mode        = ctrl_q.f.led_mode;
   end

   // an access cycle must follow a setup cycle of the same transfer
   a_apb_setup_first: assert property (@(posedge clk_usb) disable iff (reset)
      penable_i |-> psel_i && $past(psel_i && !penable_i));

endmodule

/* rtl/panel_driver.sv */
`timescale 1ns/1ps

module panel_driver import clk_monitor_pkg::*; (
   input  logic          clk_usb,
   input  logic          reset,
   input  panel_cfg_t    cfg_i,
   input  meter_result_t result_i,
   input  logic [1:0]    beat_i,
   input  logic          flash_i,
   input  logic          ext_clk_i,
   output logic          led_a_o,
   output logic          led_b_o,
   output logic          amp_gain_o
);

   logic       ext_meta;
   logic       ext_sync;
   logic       meas_tgl;      // flips on every finished measurement
   logic [8:0] acc_q;         // bit 8 is the carry
   logic       led_a_q;
   logic       led_b_q;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ext_meta <= 1'b0;
         ext_sync <= 1'b0;
         meas_tgl <= 1'b0;
         acc_q    <= '0;
      end else begin
         ext_meta <= ext_clk_i;
         ext_sync <= ext_meta;
         if (result_i.measure_pulse)
            meas_tgl <= ~meas_tgl;
         acc_q <= {1'b0, acc_q[7:0]} + {1'b0, cfg_i.gain};   // first-order PWM
      end
   end

   assign amp_gain_o = acc_q[8];

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         led_a_q <= 1'b0;
         led_b_q <= 1'b0;
      end else if (result_i.change) begin
         led_a_q <= flash_i;    // alarm overrides any mode
         led_b_q <= flash_i;
      end else begin
         unique case (cfg_i.led_mode)
            LED_STATUS: begin
               led_a_q <= result_i.valid;
               led_b_q <= meas_tgl;
            end
            LED_HEARTBEAT: begin
               led_a_q <= beat_i[1];
               led_b_q <= beat_i[0];
            end
            LED_METER: begin
               led_a_q <= ext_sync;
               led_b_q <= result_i.change;
            end
            LED_GAIN: begin
               led_a_q <= acc_q[8];
               led_b_q <= ~acc_q[8];
            end
         endcase
      end
   end

   assign led_a_o = led_a_q;
   assign led_b_o = led_b_q;

   a_alarm_leds_equal: assert property (@(posedge clk_usb) disable iff (reset)
      result_i.change |=> (led_a_o == led_b_o));

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the clk_monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_clk_monitor \
   -f clk_monitor.f \
   -o tb_clk_monitor

out=$(./obj_dir/tb_clk_monitor)
echo "$out"

if echo "$out" | grep -q "STATUS: PASS"; then
   exit 0
else
   exit 1
fi

/* sim/tb_clk_monitor.sv */
`timescale 1ns/1ps
`include "clk_monitor_defs.svh"

module tb_clk_monitor;

   localparam int WIN         = 200;    // measurement window used by the tests
   localparam int WIN_TIMEOUT = 1100;   // longer than the reset window
   localparam int LIMIT       = 2;

   logic        clk_usb = 1'b0;
   logic        reset = 1'b1;
   logic [7:0]  paddr = '0;
   logic        psel = 1'b0;
   logic        penable = 1'b0;
   logic        pwrite = 1'b0;
   logic [31:0] pwdata = '0;
   logic        ext_clk = 1'b0;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        led_a;
   logic        led_b;
   logic        amp_gain;

   int          ext_period = 8;         // target clock period in clk_usb cycles
   logic [15:0] lfsr = 16'd97;
   int          errors = 0;
   int          timeouts = 0;
   logic        alarm_chk = 1'b0;       // alarm known to be set
   logic        gain_chk = 1'b0;        // LED_GAIN mode settled

   clk_monitor_top dut_i (
      .clk_usb    (clk_usb),
      .reset      (reset),
      .paddr_i    (paddr),
      .psel_i     (psel),
      .penable_i  (penable),
      .pwrite_i   (pwrite),
      .pwdata_i   (pwdata),
      .ext_clk_i  (ext_clk),
      .prdata_o   (prdata),
      .pready_o   (pready),
      .pslverr_o  (pslverr),
      .led_a_o    (led_a),
      .led_b_o    (led_b),
      .amp_gain_o (amp_gain)
   );

   always #10 clk_usb = ~clk_usb;

   // target clock, whole clk_usb cycles per phase
   always begin : ext_clock_gen
      int ph;
      for (ph = 0; ph < ext_period / 2; ph++)
         @(posedge clk_usb);
      ext_clk <= 1'b1;
      for (ph = 0; ph < ext_period - ext_period / 2; ph++)
         @(posedge clk_usb);
      ext_clk <= 1'b0;
   end

   // the slave has no wait states
   a_pready_high: assert property (@(posedge clk_usb) disable iff (reset) pready)
      else begin
         errors++;
         $display("Error %0t: pready is low", $time);
      end

   a_alarm_leds: assert property (@(posedge clk_usb) disable iff (reset)
      alarm_chk |-> (led_a == led_b))
      else begin
         errors++;
         $display("Error %0t: LEDs differ while the alarm is set", $time);
      end

   a_gain_leds: assert property (@(posedge clk_usb) disable iff (reset)
      gain_chk |-> (led_a == $past(amp_gain)) && (led_b == !$past(amp_gain)))
      else begin
         errors++;
         $display("Error %0t: LEDs do not follow amp_gain in LED_GAIN mode", $time);
      end

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0])
         n = n ^ 16'hB400;              // taps 16, 14, 13, 11
      return n;
   endfunction

   task automatic draw_bits(input int nbits, output int value);
      value = 0;
      for (int i = 0; i < nbits; i++) begin
         lfsr = lfsr_next(lfsr);
         value = (value << 1) | int'(lfsr[0]);
      end
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
      @(posedge clk_usb);
      paddr   <= addr;
      pwdata  <= data;
      pwrite  <= 1'b1;
      psel    <= 1'b1;
      penable <= 1'b0;
      @(posedge clk_usb);
      penable <= 1'b1;
      @(negedge clk_usb);
      err = pslverr;
      @(posedge clk_usb);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
      @(posedge clk_usb);
      paddr   <= addr;
      pwrite  <= 1'b0;
      psel    <= 1'b1;
      penable <= 1'b0;
      @(posedge clk_usb);
      penable <= 1'b1;
      @(negedge clk_usb);               // prdata is stable mid access cycle
      data = prdata;
      err  = pslverr;
      @(posedge clk_usb);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("Error %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      assert (got === exp) else begin
         errors++;
         $display("Error %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   // led_b toggles once per finished window in LED_STATUS mode
   task automatic wait_window_end();
      logic last;
      int   n;
      @(negedge clk_usb);
      last = led_b;
      n = 0;
      while (led_b == last && n < WIN_TIMEOUT) begin
         @(negedge clk_usb);
         n++;
      end
      if (led_b == last) begin
         timeouts++;
         $display("Timeout: no measurement window finished by %0t", $time);
      end
   endtask

   task automatic wait_alarm(input int max_cycles);
      logic [31:0] st;
      logic        e;
      int          spent;
      st = '0;
      spent = 0;
      while (!st[0] && spent < max_cycles) begin
         apb_read(`REG_STATUS, st, e);
         spent = spent + 3;             // one read spans three clk_usb cycles
      end
      if (!st[0]) begin
         timeouts++;
         $display("Timeout: change alarm not set within %0d cycles at %0t", max_cycles, $time);
      end
   endtask

   initial begin
      int          p;
      int          p2;
      int          gain;
      int          ones;
      int          lo;
      logic [31:0] rd;
      logic [31:0] ctrl_wr;
      logic        err;

      draw_bits(3, p);
      p = p + 4;                        // 4 to 11 cycles
      ext_period = p;
      repeat (2) @(posedge clk_usb);
      reset <= 1'b0;

      // reset state
      @(negedge clk_usb);
      check_bit("amp_gain after reset", amp_gain, 1'b0);
      check_bit("led_a after reset", led_a, 1'b0);
      check_bit("led_b after reset", led_b, 1'b0);
      apb_read(`REG_STATUS, rd, err);
      check_word("STATUS after reset", rd, 32'h0);

      // register access, reserved bits and clear_change read zero
      draw_bits(8, gain);
      ctrl_wr = {20'hFFFFF, 1'b1, 1'b1, 2'd1, 8'(gain)};
      apb_write(`REG_CTRL, ctrl_wr, err);
      check_bit("CTRL write pslverr", err, 1'b0);
      apb_read(`REG_CTRL, rd, err);
      check_word("CTRL", rd, {20'h0, 1'b0, 1'b1, 2'd1, 8'(gain)});
      check_bit("CTRL read pslverr", err, 1'b0);
      apb_write(`REG_CTRL, 32'h400, err);          // monitor off across the long reset window
      apb_write(`REG_WINDOW, 32'(WIN), err);
      apb_read(`REG_WINDOW, rd, err);
      check_word("WINDOW", rd, 32'(WIN));
      apb_write(`REG_LIMIT, 32'(LIMIT), err);
      apb_read(`REG_LIMIT, rd, err);
      check_word("LIMIT", rd, 32'(LIMIT));
      apb_read(8'h14, rd, err);
      check_word("unmapped read data", rd, 32'h0);
      check_bit("unmapped read pslverr", err, 1'b1);
      apb_write(8'h20, 32'hDEADBEEF, err);
      check_bit("unmapped write pslverr", err, 1'b1);

      // measurement, the second window end closes a full WIN window
      wait_window_end();
      wait_window_end();
      apb_read(`REG_STATUS, rd, err);
      check_word("STATUS once measured", rd, 32'h2);
      apb_read(`REG_FREQ, rd, err);
      lo = WIN / p;
      assert (rd >= 32'(lo) && rd <= 32'(lo + 1)) else begin
         errors++;
         $display("Error %0t: FREQ is %0d, expected %0d or %0d", $time, rd, lo, lo + 1);
      end

      // period jump of four cycles moves the count far beyond LIMIT
      apb_write(`REG_CTRL, 32'h0, err);            // monitor on
      p2 = (p >= 8) ? p - 4 : p + 4;
      ext_period = p2;
      wait_alarm(2 * WIN + 20);
      alarm_chk <= 1'b1;
      repeat (2 * WIN + 10) @(posedge clk_usb);   // let the mixed windows pass
      alarm_chk <= 1'b0;
      apb_write(`REG_CTRL, 32'h800, err);          // clear_change
      apb_read(`REG_STATUS, rd, err);
      check_bit("STATUS.change after clear", rd[0], 1'b0);
      repeat (3) begin
         wait_window_end();
         apb_read(`REG_STATUS, rd, err);
         check_bit("STATUS.change at steady period", rd[0], 1'b0);
      end

      // same jump with the monitor disabled
      apb_write(`REG_CTRL, 32'h400, err);
      ext_period = p;
      repeat (3) begin
         wait_window_end();
         apb_read(`REG_STATUS, rd, err);
         check_bit("STATUS.change while disabled", rd[0], 1'b0);
      end

      // gain PWM in LED_GAIN mode
      draw_bits(8, gain);
      apb_write(`REG_CTRL, 32'h400 | 32'h300 | 32'(gain), err);
      repeat (2) @(posedge clk_usb);
      gain_chk <= 1'b1;
      ones = 0;
      repeat (256) begin
         @(negedge clk_usb);
         if (amp_gain)
            ones++;
      end
      gain_chk <= 1'b0;
      assert (ones == gain) else begin
         errors++;
         $display("Error %0t: amp_gain high %0d of 256 cycles, gain %0d", $time, ones, gain);
      end

      $display("tb_clk_monitor done with %0d errors and %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule
